// File: mem_subsys.f
source/mem_pkg.sv
source/cpu_pkg.sv
source/load_extend.sv
source/data_ram.sv
source/byte_mem_ctrl.sv
source/mem_stage_ctrl.sv
source/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mem_subsys.f --top-module tb_mem_subsys -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mem_subsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: sim/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
    import cpu_pkg::*, mem_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2500; // ~340 requests at up to 7 cycles, plus reset.
    localparam int RAND_REQS      = 300;

    logic     clk;
    logic     rst;
    logic     req_valid_i;
    mem_req_t req_i;
    logic     stall_o;
    logic     wb_valid_o;
    wb_t      wb_o;

    integer   seed = 80;
    int       cycle_cnt;
    int       data_errs;
    int       dest_errs;
    int       flow_errs;
    byte_t    shadow [RAM_BYTES]; // expected RAM contents.
    wb_t      exp_q [$];
    wb_t      expd;

    mem_subsys_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .stall_o     (stall_o),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int size_bytes(input acc_size_e size);
        case (size)
            ACC_HALF: return 2;
            ACC_WORD: return 4;
            default:  return 1;
        endcase
    endfunction

    // little-endian gather from the shadow, then extension by size and sign.
    function automatic word_t exp_load(input byte_t mem [RAM_BYTES], input mem_addr_t addr,
                                       input acc_size_e size, input logic sgn);
        word_t     raw;
        ram_addr_t a;
        int        k;
        raw = '0;
        for (k = 0; k < size_bytes(size); k++) begin
            a = addr[7:0] + k[7:0]; // RAM address wraps at 256.
            raw[8*k +: 8] = mem[a];
        end
        case (size)
            ACC_BYTE: return sgn ? {{24{raw[7]}}, raw[7:0]} : {24'd0, raw[7:0]};
            ACC_HALF: return sgn ? {{16{raw[15]}}, raw[15:0]} : {16'd0, raw[15:0]};
            default:  return raw;
        endcase
    endfunction

    function automatic mem_req_t build_req(input reg_addr_t dest, input logic wreg,
                                           input word_t wdata, input mem_addr_t addr,
                                           input logic store, input acc_size_e size,
                                           input logic sgn);
        mem_req_t r;
        r.dest      = dest;
        r.wreg      = wreg;
        r.wdata     = wdata;
        r.addr      = addr;
        r.store     = store;
        r.size      = size;
        r.is_signed = sgn;
        return r;
    endfunction

    task automatic check_data(input word_t exp_d, input word_t act_d);
        if (act_d !== exp_d) begin
            data_errs++;
            $display("ERR %0t: wb data expected %h, got %h", $time, exp_d, act_d);
        end
    endtask

    task automatic check_dest(input reg_addr_t exp_r, input reg_addr_t act_r,
                              input logic exp_w, input logic act_w);
        if (act_r !== exp_r || act_w !== exp_w) begin
            dest_errs++;
            $display("ERR %0t: wb dest/wreg expected %0d/%b, got %0d/%b",
                     $time, exp_r, exp_w, act_r, act_w);
        end
    endtask

    task automatic check_idle(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            if (stall_o !== 1'b0 || wb_valid_o !== 1'b0 || wb_o !== '0) begin
                flow_errs++;
                $display("ERR %0t: outputs not idle after reset (stall %b, wb_valid %b, wb %h)",
                         $time, stall_o, wb_valid_o, wb_o);
            end
            @(negedge clk);
        end
    endtask

    // called on a falling edge, returns on a falling edge with the stall low.
    task automatic issue_req(input mem_req_t req);
        wb_t       w;
        ram_addr_t a;
        int        k;
        int        waits;
        int        exp_waits;
        w.dest = req.dest;
        w.wreg = req.wreg;
        w.data = req.wdata;
        if (req.size != ACC_NONE && req.store) begin
            w.wreg = 1'b0;
            for (k = 0; k < size_bytes(req.size); k++) begin
                a = req.addr[7:0] + k[7:0];
                shadow[a] = req.wdata[8*k +: 8];
            end
        end else if (req.size != ACC_NONE) begin
            w.data = exp_load(shadow, req.addr, req.size, req.is_signed);
        end
        exp_q.push_back(w);
        req_i       = req;
        req_valid_i = 1'b1;
        @(negedge clk);
        req_valid_i = 1'b0;
        // stall covers the start cycle and the byte cycles up to done.
        exp_waits = (req.size == ACC_NONE) ? 0 : size_bytes(req.size) + 2;
        waits     = 0;
        while (stall_o) begin
            @(negedge clk);
            waits++;
        end
        if (waits != exp_waits) begin
            flow_errs++;
            $display("stall_o was high for %0d cycles instead of %0d at %0t",
                     waits, exp_waits, $time);
        end
        if (!wb_valid_o) begin
            flow_errs++;
            $display("no writeback in the cycle the stall fell at %0t", $time);
        end
    endtask

    // one writeback per request, in order.
    always @(negedge clk) begin
        if (!rst && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                flow_errs++;
                $display("writeback at %0t with no request outstanding", $time);
            end else begin
                expd = exp_q.pop_front();
                check_data(expd.data, wb_o.data);
                check_dest(expd.dest, wb_o.dest, expd.wreg, wb_o.wreg);
            end
            if (stall_o) begin
                flow_errs++;
                $display("stall_o still high in the writeback cycle at %0t", $time);
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        mem_req_t req;
        logic [31:0] r;
        int i;
        data_errs   = 0;
        dest_errs   = 0;
        flow_errs   = 0;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_idle(3);

        // pass-through.
        issue_req(build_req(5'd1, 1'b1, 32'h1234_5678, 32'h0000_0010, 1'b0, ACC_NONE, 1'b0));
        issue_req(build_req(5'd31, 1'b0, 32'hffff_0001, 32'h0000_0020, 1'b1, ACC_NONE, 1'b1));
        issue_req(build_req(5'd7, 1'b1, 32'h8000_0000, 32'h0000_0000, 1'b0, ACC_NONE, 1'b1));

        // store then load, same size and address.
        issue_req(build_req(5'd2, 1'b1, 32'hdead_beef, 32'h0000_0010, 1'b1, ACC_WORD, 1'b0));
        issue_req(build_req(5'd3, 1'b1, 32'h0, 32'h0000_0010, 1'b0, ACC_WORD, 1'b0));
        issue_req(build_req(5'd4, 1'b1, 32'h0000_8001, 32'h0000_0022, 1'b1, ACC_HALF, 1'b0));
        issue_req(build_req(5'd5, 1'b1, 32'h0, 32'h0000_0022, 1'b0, ACC_HALF, 1'b0));
        issue_req(build_req(5'd6, 1'b1, 32'h0000_00a5, 32'h0000_0035, 1'b1, ACC_BYTE, 1'b0));
        issue_req(build_req(5'd8, 1'b1, 32'h0, 32'h0000_0035, 1'b0, ACC_BYTE, 1'b0));
        issue_req(build_req(5'd9, 1'b1, 32'h0, 32'h0000_0035, 1'b0, ACC_BYTE, 1'b1));
        issue_req(build_req(5'd10, 1'b1, 32'h0, 32'h0000_0022, 1'b0, ACC_HALF, 1'b1));
        // word across the top of the RAM, upper address bits ignored.
        issue_req(build_req(5'd11, 1'b1, 32'hcafe_f00d, 32'h0000_00fe, 1'b1, ACC_WORD, 1'b0));
        issue_req(build_req(5'd12, 1'b1, 32'h0, 32'h0001_00fe, 1'b0, ACC_WORD, 1'b0));

        // sign extension across bytes of mixed-size stores.
        issue_req(build_req(5'd13, 1'b1, 32'h80ff_7f80, 32'h0000_0070, 1'b1, ACC_WORD, 1'b0));
        issue_req(build_req(5'd14, 1'b1, 32'h0000_9c00, 32'h0000_0072, 1'b1, ACC_HALF, 1'b0));
        issue_req(build_req(5'd14, 1'b1, 32'h0000_00e1, 32'h0000_0074, 1'b1, ACC_BYTE, 1'b0));
        for (i = 0; i < 4; i++) begin
            issue_req(build_req(5'd15, 1'b1, 32'h0, 32'h70 + i, 1'b0, ACC_BYTE, 1'b1));
            issue_req(build_req(5'd16, 1'b1, 32'h0, 32'h70 + i, 1'b0, ACC_BYTE, 1'b0));
            issue_req(build_req(5'd17, 1'b1, 32'h0, 32'h70 + i, 1'b0, ACC_HALF, 1'b1));
            issue_req(build_req(5'd18, 1'b1, 32'h0, 32'h70 + i, 1'b0, ACC_HALF, 1'b0));
        end
        issue_req(build_req(5'd19, 1'b1, 32'h0, 32'h0000_0071, 1'b0, ACC_WORD, 1'b0));

        // fill the random window 0x40..0x63 so every random load reads known bytes.
        for (i = 0; i < 9; i++) begin
            issue_req(build_req(5'd20, 1'b0, $random(seed), 32'h40 + 4 * i, 1'b1,
                                ACC_WORD, 1'b0));
        end

        for (i = 0; i < RAND_REQS; i++) begin
            r             = $random(seed);
            req.dest      = r[4:0];
            req.wreg      = r[5];
            req.store     = r[6];
            req.size      = acc_size_e'(r[9:8]);
            req.is_signed = r[10];
            req.addr      = {r[31:16], 8'h00, 8'h40 + {3'b000, r[15:11]}};
            req.wdata     = $random(seed);
            issue_req(req);
        end

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            flow_errs++;
            $display("%0d requests never got a writeback", exp_q.size());
        end
        $display("errors: data %0d, dest %0d, flow %0d", data_errs, dest_errs, flow_errs);
        if (data_errs + dest_errs + flow_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
    import cpu_pkg::*, mem_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             req_valid_i,
    input  wire mem_req_t   req_i,

    output logic            stall_o,
    output logic            wb_valid_o,
    output wb_t             wb_o
);

    logic      mc_start;
    mc_cmd_t   mc_cmd;
    logic      mc_done;
    word_t     mc_rdata;
    acc_size_e ext_size;
    logic      ext_signed;
    word_t     ext_data;
    ram_port_t ram_port;
    byte_t     ram_rdata;

    mem_stage_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .mc_done_i    (mc_done),
        .ext_data_i   (ext_data),
        .mc_start_o   (mc_start),
        .mc_cmd_o     (mc_cmd),
        .ext_size_o   (ext_size),
        .ext_signed_o (ext_signed),
        .stall_o      (stall_o),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

    byte_mem_ctrl u_bmc (
        .clk         (clk),
        .rst         (rst),
        .mc_start_i  (mc_start),
        .mc_cmd_i    (mc_cmd),
        .mc_done_o   (mc_done),
        .mc_rdata_o  (mc_rdata),
        .ram_port_o  (ram_port),
        .ram_rdata_i (ram_rdata)
    );

    load_extend u_ext (
        .data_i   (mc_rdata),
        .size_i   (ext_size),
        .signed_i (ext_signed),
        .data_o   (ext_data)
    );

    data_ram u_ram (
        .clk     (clk),
        .port_i  (ram_port),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

// File: source/mem_stage_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_ctrl
    import cpu_pkg::*, mem_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             req_valid_i,
    input  wire mem_req_t   req_i,

    // byte sequencer and load extension.
    input  wire             mc_done_i,
    input  wire word_t      ext_data_i,
    output logic            mc_start_o,
    output mc_cmd_t         mc_cmd_o,
    output acc_size_e       ext_size_o,
    output logic            ext_signed_o,

    output logic            stall_o,
    output logic            wb_valid_o,
    output wb_t             wb_o
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE, // start pulse to the sequencer.
        WAIT   // bytes in flight.
    } state_e;

    state_e   state_q;
    mem_req_t req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            wb_valid_o <= 1'b0;
            wb_o       <= '0;
        end else begin
            wb_valid_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        if (req_i.size == ACC_NONE) begin // no memory, straight to wb.
                            wb_valid_o <= 1'b1;
                            wb_o.dest  <= req_i.dest;
                            wb_o.wreg  <= req_i.wreg;
                            wb_o.data  <= req_i.wdata;
                        end else begin
                            state_q <= ISSUE;
                        end
                    end
                end
                ISSUE: state_q <= WAIT;
                WAIT: begin
                    if (mc_done_i) begin
                        wb_valid_o <= 1'b1;
                        wb_o.dest  <= req_q.dest;
                        wb_o.wreg  <= req_q.wreg & ~req_q.store; // stores never write back.
                        wb_o.data  <= req_q.store ? req_q.wdata : ext_data_i;
                        state_q    <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request payload, taken only when a new one is accepted.
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid_i) begin
            req_q <= req_i;
        end
    end

    always_comb begin
        mc_cmd_o.addr  = req_q.addr;
        mc_cmd_o.wdata = req_q.wdata;
        mc_cmd_o.store = req_q.store;
        mc_cmd_o.size  = req_q.size;
    end

    assign mc_start_o   = (state_q == ISSUE);
    assign stall_o      = (state_q != IDLE); // held until the writeback cycle.
    assign ext_size_o   = req_q.size;
    assign ext_signed_o = req_q.is_signed;

endmodule

`default_nettype wire

// File: source/byte_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module byte_mem_ctrl
    import cpu_pkg::*, mem_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             mc_start_i,
    input  wire mc_cmd_t    mc_cmd_i,
    output logic            mc_done_o,
    output word_t           mc_rdata_o,

    output ram_port_t       ram_port_o,
    input  wire byte_t      ram_rdata_i
);

    mc_cmd_t    cmd_q;
    logic       busy_q;
    logic [1:0] cnt_q;     // index of the byte on the RAM port.
    logic [1:0] last_idx;
    logic       rd_pend_q; // a load byte returns this cycle.
    logic [1:0] rd_idx_q;
    logic       done_q;
    word_t      asm_q;
    word_t      asm_d;

    always_comb begin
        case (cmd_q.size)
            ACC_HALF: last_idx = 2'd1;
            ACC_WORD: last_idx = 2'd3;
            default:  last_idx = 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            rd_pend_q <= 1'b0;
            rd_idx_q  <= '0;
            done_q    <= 1'b0;
        end else begin
            rd_pend_q <= busy_q & ~cmd_q.store;
            rd_idx_q  <= cnt_q;
            done_q    <= busy_q && (cnt_q == last_idx); // one cycle after the last byte.
            if (mc_start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                if (cnt_q == last_idx) begin
                    busy_q <= 1'b0;
                end
                cnt_q <= cnt_q + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mc_start_i) begin
            cmd_q <= mc_cmd_i;
        end
    end

    // little-endian assembly, the returning byte merged in the same cycle.
    always_comb begin
        asm_d = asm_q;
        if (rd_pend_q) begin
            asm_d[8*rd_idx_q +: 8] = ram_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (mc_start_i) begin
            asm_q <= '0; // unused upper bytes read as zero.
        end else begin
            asm_q <= asm_d;
        end
    end

    always_comb begin
        ram_port_o.addr  = cmd_q.addr[7:0] + {6'd0, cnt_q}; // wraps inside the RAM.
        ram_port_o.we    = busy_q & cmd_q.store;
        ram_port_o.wdata = cmd_q.wdata[8*cnt_q +: 8];
    end

    assign mc_done_o  = done_q;
    assign mc_rdata_o = asm_d;

endmodule

`default_nettype wire

// File: source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import mem_pkg::*;
(
    input  wire             clk,
    input  wire ram_port_t  port_i,
    output byte_t           rdata_o
);

    byte_t mem_q [RAM_BYTES];

    always_ff @(posedge clk) begin
        if (port_i.we) begin
            mem_q[port_i.addr] <= port_i.wdata;
        end
        rdata_o <= mem_q[port_i.addr]; // old contents on a write.
    end

endmodule

`default_nettype wire

// File: source/load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module load_extend
    import cpu_pkg::*, mem_pkg::*;
(
    input  wire word_t      data_i,
    input  wire acc_size_e  size_i,
    input  wire             signed_i,
    output word_t           data_o
);

    logic fill_b;
    logic fill_h;

    assign fill_b = signed_i & data_i[7];  // zero fill when unsigned.
    assign fill_h = signed_i & data_i[15];

    always_comb begin
        case (size_i)
            ACC_BYTE: data_o = {{24{fill_b}}, data_i[7:0]};
            ACC_HALF: data_o = {{16{fill_h}}, data_i[15:0]};
            default:  data_o = data_i; // word is taken as is.
        endcase
    end

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    import mem_pkg::*;

    typedef bus_word_t  word_t;     // data word.
    typedef bus_word_t  mem_addr_t; // byte address.
    typedef logic [4:0] reg_addr_t;

    // request handed over by the execute stage.
    typedef struct packed {
        reg_addr_t dest;
        logic      wreg;      // write the destination register.
        word_t     wdata;     // alu result or store data.
        mem_addr_t addr;
        logic      store;     // 1 for store, 0 for load.
        acc_size_e size;
        logic      is_signed; // only meaningful for loads.
    } mem_req_t;

    // writeback to the register file.
    typedef struct packed {
        reg_addr_t dest;
        logic      wreg;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int unsigned RAM_BYTES = 256; // depth of the data RAM.

    // 32-bit lane of the memory bus, shared with the pipeline types.
    typedef logic [31:0] bus_word_t;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] ram_addr_t; // low address bits seen by the RAM.

    typedef enum logic [1:0] {
        ACC_NONE, // no memory access.
        ACC_BYTE,
        ACC_HALF,
        ACC_WORD
    } acc_size_e;

    // command from the stage control to the byte sequencer.
    typedef struct packed {
        bus_word_t addr;
        bus_word_t wdata;
        logic      store;
        acc_size_e size;
    } mc_cmd_t;

    typedef struct packed {
        ram_addr_t addr;
        logic      we;
        byte_t     wdata;
    } ram_port_t;

endpackage

`default_nettype wire
